// ==== flist.f ====
src/axi_lite_pkg.sv
src/axi_lite_write_arbiter.sv
src/axi_lite_read_arbiter.sv
src/axi_lite_arbiter.sv
verification/tb_clock_gen.sv
verification/axi_lite_arbiter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=axi_lite_arbiter_tb

verilator --binary --timing --assert -f flist.f --top-module "$TOP" \
    -Mdir obj_dir -o "${TOP}_sim"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"${TOP}_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== verification/axi_lite_arbiter_tb.sv ====
// Testbench for the two-master AXI4-lite arbiter
// Random traffic on both masters and the slave checked against a grant model
`timescale 1ns/1ns
`default_nettype none

module axi_lite_arbiter_tb;

    localparam int NUM_CYCLES  = 2000;
    localparam int CLK_PERIOD  = 8;
    localparam int WATCHDOG_NS = (NUM_CYCLES + 200) * CLK_PERIOD;

    logic AXI_ACLK;
    logic AXI_ARESETN;

    axi_lite_pkg::axi_aw_t a_aw, b_aw, o_aw;
    axi_lite_pkg::axi_w_t  a_w, b_w, o_w;
    axi_lite_pkg::axi_b_t  a_b, b_b, o_b;
    axi_lite_pkg::axi_ar_t a_ar, b_ar, o_ar;
    axi_lite_pkg::axi_r_t  a_r, b_r, o_r;

    logic a_awvalid, a_awready, a_wvalid, a_wready, a_bvalid, a_bready;
    logic a_arvalid, a_arready, a_rvalid, a_rready;
    logic b_awvalid, b_awready, b_wvalid, b_wready, b_bvalid, b_bready;
    logic b_arvalid, b_arready, b_rvalid, b_rready;
    logic o_awvalid, o_awready, o_wvalid, o_wready, o_bvalid, o_bready;
    logic o_arvalid, o_arready, o_rvalid, o_rready;

    axi_lite_pkg::grant_state_t wr_model;
    axi_lite_pkg::grant_state_t rd_model;

    logic [31:0] lfsr_state;
    logic        check_en;
    logic        reset_check;
    int          errors = 0;
    int          checks = 0;
    int          prio_hits = 0;
    int          lock_hits = 0;
    int          indep_hits = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk(AXI_ACLK)
    );

    axi_lite_arbiter axi_lite_arbiter_inst (
        .*
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [127:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[126:0], lfsr_state[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_random();
        logic [127:0] r;
        // Valids high three times in four, so A and B often collide
        take_bits(21, r);
        a_awvalid <= |r[1:0];
        a_wvalid  <= |r[3:2];
        b_awvalid <= |r[5:4];
        b_wvalid  <= |r[7:6];
        a_arvalid <= |r[9:8];
        b_arvalid <= |r[11:10];
        a_bready  <= r[12];
        b_bready  <= r[13];
        a_rready  <= r[14];
        b_rready  <= r[15];
        o_awready <= r[16];
        o_wready  <= r[17];
        o_bvalid  <= r[18];
        o_arready <= r[19];
        o_rvalid  <= r[20];
        take_bits(35, r);
        a_aw <= r[34:0];
        take_bits(35, r);
        b_aw <= r[34:0];
        take_bits(72, r);
        a_w <= r[71:0];
        take_bits(72, r);
        b_w <= r[71:0];
        take_bits(35, r);
        a_ar <= r[34:0];
        take_bits(35, r);
        b_ar <= r[34:0];
        take_bits(2, r);
        o_b <= r[1:0];
        take_bits(66, r);
        o_r <= r[65:0];
    endtask

    // Grant model advanced from the inputs seen at each edge
    always @(posedge AXI_ACLK) begin
        logic a_wreq;
        logic b_wreq;
        a_wreq = a_awvalid | a_wvalid;
        b_wreq = b_awvalid | b_wvalid;
        if (!AXI_ARESETN) begin
            wr_model <= axi_lite_pkg::GRANT_IDLE;
            rd_model <= axi_lite_pkg::GRANT_IDLE;
        end else begin
            case (wr_model)
                axi_lite_pkg::GRANT_IDLE: begin
                    if (a_wreq) begin
                        wr_model <= axi_lite_pkg::GRANT_A;
                    end else if (b_wreq) begin
                        wr_model <= axi_lite_pkg::GRANT_B;
                    end
                end
                axi_lite_pkg::GRANT_A: begin
                    if (o_bvalid && a_bready) begin
                        wr_model <= axi_lite_pkg::GRANT_IDLE;
                    end
                end
                axi_lite_pkg::GRANT_B: begin
                    if (o_bvalid && b_bready) begin
                        wr_model <= axi_lite_pkg::GRANT_IDLE;
                    end
                end
                default: wr_model <= axi_lite_pkg::GRANT_IDLE;
            endcase
            case (rd_model)
                axi_lite_pkg::GRANT_IDLE: begin
                    if (a_arvalid) begin
                        rd_model <= axi_lite_pkg::GRANT_A;
                    end else if (b_arvalid) begin
                        rd_model <= axi_lite_pkg::GRANT_B;
                    end
                end
                axi_lite_pkg::GRANT_A: begin
                    if (o_rvalid && a_rready) begin
                        rd_model <= axi_lite_pkg::GRANT_IDLE;
                    end
                end
                axi_lite_pkg::GRANT_B: begin
                    if (o_rvalid && b_rready) begin
                        rd_model <= axi_lite_pkg::GRANT_IDLE;
                    end
                end
                default: rd_model <= axi_lite_pkg::GRANT_IDLE;
            endcase
        end
    end

    // Outputs compared mid-cycle after inputs settle
    always @(negedge AXI_ACLK) begin
        logic a_wreq;
        logic b_wreq;
        logic wsel;
        logic rsel;
        a_wreq = a_awvalid | a_wvalid;
        b_wreq = b_awvalid | b_wvalid;
        wsel = (wr_model == axi_lite_pkg::GRANT_B) ||
               (wr_model == axi_lite_pkg::GRANT_IDLE && b_wreq && !a_wreq);
        rsel = (rd_model == axi_lite_pkg::GRANT_B) ||
               (rd_model == axi_lite_pkg::GRANT_IDLE && b_arvalid && !a_arvalid);
        if (reset_check) begin
            check_val("reset quiet", 128'(0), 128'({o_awvalid, o_wvalid, o_arvalid,
                a_awready, a_wready, a_arready, b_awready, b_wready, b_arready,
                a_bvalid, a_rvalid, b_bvalid, b_rvalid}));
        end
        if (check_en) begin
            check_val("routing o_aw", 128'(wsel ? b_aw : a_aw), 128'(o_aw));
            check_val("routing o_awvalid", 128'(wsel ? b_awvalid : a_awvalid), 128'(o_awvalid));
            check_val("routing o_w", 128'(wsel ? b_w : a_w), 128'(o_w));
            check_val("routing o_wvalid", 128'(wsel ? b_wvalid : a_wvalid), 128'(o_wvalid));
            check_val("routing o_ar", 128'(rsel ? b_ar : a_ar), 128'(o_ar));
            check_val("routing o_arvalid", 128'(rsel ? b_arvalid : a_arvalid), 128'(o_arvalid));
            check_val("return o_bready", 128'(wsel ? b_bready : a_bready), 128'(o_bready));
            check_val("return o_rready", 128'(rsel ? b_rready : a_rready), 128'(o_rready));
            check_val("return a_awready", 128'(!wsel && o_awready), 128'(a_awready));
            check_val("return a_wready", 128'(!wsel && o_wready), 128'(a_wready));
            check_val("return a_bvalid", 128'(!wsel && o_bvalid), 128'(a_bvalid));
            check_val("return a_b", wsel ? 128'(0) : 128'(o_b), 128'(a_b));
            check_val("return a_arready", 128'(!rsel && o_arready), 128'(a_arready));
            check_val("return a_rvalid", 128'(!rsel && o_rvalid), 128'(a_rvalid));
            check_val("return a_r", rsel ? 128'(0) : 128'(o_r), 128'(a_r));
            check_val("return b_awready", 128'(wsel && o_awready), 128'(b_awready));
            check_val("return b_wready", 128'(wsel && o_wready), 128'(b_wready));
            check_val("return b_bvalid", 128'(wsel && o_bvalid), 128'(b_bvalid));
            check_val("return b_b", wsel ? 128'(o_b) : 128'(0), 128'(b_b));
            check_val("return b_arready", 128'(rsel && o_arready), 128'(b_arready));
            check_val("return b_rvalid", 128'(rsel && o_rvalid), 128'(b_rvalid));
            check_val("return b_r", rsel ? 128'(o_r) : 128'(0), 128'(b_r));
            if (wr_model == axi_lite_pkg::GRANT_IDLE && a_wreq && b_wreq) begin
                prio_hits++;
            end
            if ((wr_model == axi_lite_pkg::GRANT_A && b_wreq) ||
                (wr_model == axi_lite_pkg::GRANT_B && a_wreq) ||
                (rd_model == axi_lite_pkg::GRANT_A && b_arvalid) ||
                (rd_model == axi_lite_pkg::GRANT_B && a_arvalid)) begin
                lock_hits++;
            end
            if (wr_model != axi_lite_pkg::GRANT_IDLE && rd_model != axi_lite_pkg::GRANT_IDLE &&
                wr_model != rd_model) begin
                indep_hits++;
            end
        end
    end

    initial begin
        int cov_misses;
        cov_misses = 0;
        lfsr_state = 32'h8806;
        AXI_ARESETN <= 1'b0;
        check_en    <= 1'b0;
        reset_check <= 1'b0;
        {a_awvalid, a_wvalid, a_bready, a_arvalid, a_rready} <= '0;
        {b_awvalid, b_wvalid, b_bready, b_arvalid, b_rready} <= '0;
        {o_awready, o_wready, o_bvalid, o_arready, o_rvalid} <= '0;
        {a_aw, b_aw, a_w, b_w, a_ar, b_ar, o_b, o_r} <= '0;
        repeat (5) @(posedge AXI_ACLK);
        AXI_ARESETN <= 1'b1;
        reset_check <= 1'b1;
        @(posedge AXI_ACLK);
        reset_check <= 0;
        check_en    <= 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            // Second reset mid-run while grants are held and traffic keeps running
            if (i == NUM_CYCLES / 2) begin
                AXI_ARESETN <= 1'b0;
            end else if (i == NUM_CYCLES / 2 + 5) begin
                AXI_ARESETN <= 1'b1;
            end
            drive_random();
            @(posedge AXI_ACLK);
        end
        repeat (2) @(posedge AXI_ACLK);
        if (prio_hits == 0) begin
            $display("Both masters never requested a write together while idle");
            cov_misses++;
        end
        if (lock_hits == 0) begin
            $display("No master was ever held off by a grant to the other");
            cov_misses++;
        end
        if (indep_hits == 0) begin
            $display("Write and read grants were never held by different masters");
            cov_misses++;
        end
        $display("errors %0d, checks %0d, coverage misses %0d", errors, checks, cov_misses);
        if (errors == 0 && cov_misses == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock with an 8 ns period, starting low
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int PERIOD_NS = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_lite_arbiter.sv ====
// Two-master AXI4-lite arbiter, master A over master B
// Write and read paths each keep their own grant
`timescale 1ns/1ns
`default_nettype none

module axi_lite_arbiter (
    input  wire                        AXI_ACLK,
    input  wire                        AXI_ARESETN,

    input  wire axi_lite_pkg::axi_aw_t a_aw,
    input  wire                        a_awvalid,
    output wire                        a_awready,
    input  wire axi_lite_pkg::axi_w_t  a_w,
    input  wire                        a_wvalid,
    output wire                        a_wready,
    output wire axi_lite_pkg::axi_b_t  a_b,
    output wire                        a_bvalid,
    input  wire                        a_bready,
    input  wire axi_lite_pkg::axi_ar_t a_ar,
    input  wire                        a_arvalid,
    output wire                        a_arready,
    output wire axi_lite_pkg::axi_r_t  a_r,
    output wire                        a_rvalid,
    input  wire                        a_rready,

    input  wire axi_lite_pkg::axi_aw_t b_aw,
    input  wire                        b_awvalid,
    output wire                        b_awready,
    input  wire axi_lite_pkg::axi_w_t  b_w,
    input  wire                        b_wvalid,
    output wire                        b_wready,
    output wire axi_lite_pkg::axi_b_t  b_b,
    output wire                        b_bvalid,
    input  wire                        b_bready,
    input  wire axi_lite_pkg::axi_ar_t b_ar,
    input  wire                        b_arvalid,
    output wire                        b_arready,
    output wire axi_lite_pkg::axi_r_t  b_r,
    output wire                        b_rvalid,
    input  wire                        b_rready,

    output wire axi_lite_pkg::axi_aw_t o_aw,
    output wire                        o_awvalid,
    input  wire                        o_awready,
    output wire axi_lite_pkg::axi_w_t  o_w,
    output wire                        o_wvalid,
    input  wire                        o_wready,
    input  wire axi_lite_pkg::axi_b_t  o_b,
    input  wire                        o_bvalid,
    output wire                        o_bready,
    output wire axi_lite_pkg::axi_ar_t o_ar,
    output wire                        o_arvalid,
    input  wire                        o_arready,
    input  wire axi_lite_pkg::axi_r_t  o_r,
    input  wire                        o_rvalid,
    output wire                        o_rready
);

    // Port names match one to one, so both paths bind by name
    axi_lite_write_arbiter axi_lite_write_arbiter_inst (
        .*
    );

    axi_lite_read_arbiter axi_lite_read_arbiter_inst (
        .*
    );

endmodule

`default_nettype wire

// ==== src/axi_lite_read_arbiter.sv ====
// AXI4-lite read path arbiter
// Fixed priority A over B, grant held until the R response handshake
// Runs independently of the write path
`timescale 1ns/1ns
`default_nettype none

module axi_lite_read_arbiter (
    input  wire                       AXI_ACLK,
    input  wire                       AXI_ARESETN,

    input  wire axi_lite_pkg::axi_ar_t a_ar,
    input  wire                       a_arvalid,
    output logic                      a_arready,
    output axi_lite_pkg::axi_r_t      a_r,
    output logic                      a_rvalid,
    input  wire                       a_rready,

    input  wire axi_lite_pkg::axi_ar_t b_ar,
    input  wire                       b_arvalid,
    output logic                      b_arready,
    output axi_lite_pkg::axi_r_t      b_r,
    output logic                      b_rvalid,
    input  wire                       b_rready,

    output axi_lite_pkg::axi_ar_t     o_ar,
    output logic                      o_arvalid,
    input  wire                       o_arready,
    input  wire axi_lite_pkg::axi_r_t o_r,
    input  wire                       o_rvalid,
    output logic                      o_rready
);

    axi_lite_pkg::grant_state_t rd_state;
    axi_lite_pkg::grant_state_t rd_state_next;

    logic sel_b;

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            rd_state <= axi_lite_pkg::GRANT_IDLE;
        end else begin
            rd_state <= rd_state_next;
        end
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            axi_lite_pkg::GRANT_IDLE: begin
                if (a_arvalid) begin
                    rd_state_next = axi_lite_pkg::GRANT_A;
                end else if (b_arvalid) begin
                    rd_state_next = axi_lite_pkg::GRANT_B;
                end
            end
            axi_lite_pkg::GRANT_A: begin
                if (a_rvalid && a_rready) begin
                    rd_state_next = axi_lite_pkg::GRANT_IDLE;
                end
            end
            axi_lite_pkg::GRANT_B: begin
                if (b_rvalid && b_rready) begin
                    rd_state_next = axi_lite_pkg::GRANT_IDLE;
                end
            end
            default: rd_state_next = axi_lite_pkg::GRANT_IDLE;
        endcase
    end

    // Selection follows the read state, never the write state
    always_comb begin
        case (rd_state)
            axi_lite_pkg::GRANT_A: sel_b = 1'b0;
            axi_lite_pkg::GRANT_B: sel_b = 1'b1;
            default:               sel_b = b_arvalid && !a_arvalid;
        endcase
    end

    assign o_ar      = sel_b ? b_ar : a_ar;
    assign o_arvalid = sel_b ? b_arvalid : a_arvalid;
    assign o_rready  = sel_b ? b_rready : a_rready;

    assign a_arready = !sel_b && o_arready;
    assign a_rvalid  = !sel_b && o_rvalid;
    assign a_r       = sel_b ? '0 : o_r;

    assign b_arready = sel_b && o_arready;
    assign b_rvalid  = sel_b && o_rvalid;
    assign b_r       = sel_b ? o_r : '0;

    // Read data never reaches both masters
    r_valid_onehot: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        !(a_rvalid && b_rvalid));

endmodule

`default_nettype wire

// ==== src/axi_lite_write_arbiter.sv ====
// AXI4-lite write path arbiter
// Fixed priority A over B with the grant held until the B response handshake
// Routes AW, W and B combinationally to the granted master
`timescale 1ns/1ns
`default_nettype none

module axi_lite_write_arbiter (
    input  wire                       AXI_ACLK,
    input  wire                       AXI_ARESETN,

    input  wire axi_lite_pkg::axi_aw_t a_aw,
    input  wire                       a_awvalid,
    output logic                      a_awready,
    input  wire axi_lite_pkg::axi_w_t a_w,
    input  wire                       a_wvalid,
    output logic                      a_wready,
    output axi_lite_pkg::axi_b_t      a_b,
    output logic                      a_bvalid,
    input  wire                       a_bready,

    input  wire axi_lite_pkg::axi_aw_t b_aw,
    input  wire                       b_awvalid,
    output logic                      b_awready,
    input  wire axi_lite_pkg::axi_w_t b_w,
    input  wire                       b_wvalid,
    output logic                      b_wready,
    output axi_lite_pkg::axi_b_t      b_b,
    output logic                      b_bvalid,
    input  wire                       b_bready,

    output axi_lite_pkg::axi_aw_t     o_aw,
    output logic                      o_awvalid,
    input  wire                       o_awready,
    output axi_lite_pkg::axi_w_t      o_w,
    output logic                      o_wvalid,
    input  wire                       o_wready,
    input  wire axi_lite_pkg::axi_b_t o_b,
    input  wire                       o_bvalid,
    output logic                      o_bready
);

    axi_lite_pkg::grant_state_t wr_state;
    axi_lite_pkg::grant_state_t wr_state_next;

    logic a_req;
    logic b_req;
    logic sel_b;

    // Either address or data valid counts as a write request
    assign a_req = a_awvalid | a_wvalid;
    assign b_req = b_awvalid | b_wvalid;

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            wr_state <= axi_lite_pkg::GRANT_IDLE;
        end else begin
            wr_state <= wr_state_next;
        end
    end

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            axi_lite_pkg::GRANT_IDLE: begin
                if (a_req) begin
                    wr_state_next = axi_lite_pkg::GRANT_A;
                end else if (b_req) begin
                    wr_state_next = axi_lite_pkg::GRANT_B;
                end
            end
            axi_lite_pkg::GRANT_A: begin
                if (a_bvalid && a_bready) begin
                    wr_state_next = axi_lite_pkg::GRANT_IDLE;
                end
            end
            axi_lite_pkg::GRANT_B: begin
                if (b_bvalid && b_bready) begin
                    wr_state_next = axi_lite_pkg::GRANT_IDLE;
                end
            end
            default: wr_state_next = axi_lite_pkg::GRANT_IDLE;
        endcase
    end

    // In idle, B only wins when A is quiet
    always_comb begin
        case (wr_state)
            axi_lite_pkg::GRANT_A: sel_b = 1'b0;
            axi_lite_pkg::GRANT_B: sel_b = 1'b1;
            default:               sel_b = b_req && !a_req;
        endcase
    end

    // Forward channels toward the slave
    assign o_aw      = sel_b ? b_aw : a_aw;
    assign o_awvalid = sel_b ? b_awvalid : a_awvalid;
    assign o_w       = sel_b ? b_w : a_w;
    assign o_wvalid  = sel_b ? b_wvalid : a_wvalid;
    assign o_bready  = sel_b ? b_bready : a_bready;

    // Backward channels are zero for the master not selected
    assign a_awready = !sel_b && o_awready;
    assign a_wready  = !sel_b && o_wready;
    assign a_bvalid  = !sel_b && o_bvalid;
    assign a_b       = sel_b ? '0 : o_b;

    assign b_awready = sel_b && o_awready;
    assign b_wready  = sel_b && o_wready;
    assign b_bvalid  = sel_b && o_bvalid;
    assign b_b       = sel_b ? o_b : '0;

    a_aw_ready_onehot: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        !(a_awready && b_awready));

    // A stalled response keeps the grant with A and B shut out
    a_grant_held: assert property (@(posedge AXI_ACLK) disable iff (!AXI_ARESETN)
        (wr_state == axi_lite_pkg::GRANT_A && a_bvalid && !a_bready)
            |=> (wr_state == axi_lite_pkg::GRANT_A && !b_awready && !b_wready && !b_bvalid));

endmodule

`default_nettype wire

// ==== src/axi_lite_pkg.sv ====
// AXI4-lite arbiter shared definitions
// Bus widths, channel payload structs and the grant state encoding
`default_nettype none

package axi_lite_pkg;

    localparam int AXI_DATA_WIDTH = 64;
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
    localparam int AXI_PROT_WIDTH = 3;
    localparam int AXI_RESP_WIDTH = 2;

    // Write address channel payload
    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_PROT_WIDTH-1:0] prot;
    } axi_aw_t;

    // Write data channel payload
    typedef struct packed {
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [AXI_STRB_WIDTH-1:0] strb;
    } axi_w_t;

    // Write response payload
    typedef struct packed {
        logic [AXI_RESP_WIDTH-1:0] resp;
    } axi_b_t;

    // Read address channel payload
    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_PROT_WIDTH-1:0] prot;
    } axi_ar_t;

    // Read data channel payload
    typedef struct packed {
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [AXI_RESP_WIDTH-1:0] resp;
    } axi_r_t;

    // Grant held by one master until its response completes
    typedef enum logic [1:0] {
        GRANT_IDLE = 2'd0,
        GRANT_A    = 2'd1,
        GRANT_B    = 2'd2
    } grant_state_t;

endpackage

`default_nettype wire
